// ==== tb.f ====
+incdir+.
slam_pkg.sv
ps_bram_master.sv
ekf_datapath.sv
slam_stage_ctrl.sv
rsa_top.sv
tb_wb_mem.sv
tb_rsa_top.sv

// ==== Makefile ====
# Verilator build and run for the EKF-SLAM stage sequencer

VERILATOR ?= verilator
TOP       ?= tb_rsa_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_rsa_top.sv ====
`timescale 1ns/10ps

`include "slam_settings.svh"

module tb_rsa_top;

  localparam int NUM_ROWS       = 8;
  localparam int MEM_WORDS      = 64;
  localparam int SEED           = 47;
  // slowest stage needs about 50 cycles at worst wait states
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 60;

  logic              clk;
  logic              sys_rst;
  logic              i_stage_val;
  slam_pkg::stage_t  i_stage;
  slam_pkg::lm_idx_t i_l_k;
  slam_pkg::data_t   i_rk;
  slam_pkg::data_t   i_phi;
  logic              o_stage_rdy;
  logic              o_wb_cyc;
  logic              o_wb_stb;
  logic              o_wb_we;
  slam_pkg::addr_t   o_wb_adr;
  slam_pkg::data_t   o_wb_dat;
  slam_pkg::data_t   i_wb_dat;
  logic              i_wb_ack;
  logic              o_init_predict;
  logic              o_init_newlm;
  logic              o_init_update;
  slam_pkg::data_t   o_xk;
  slam_pkg::data_t   o_yk;
  slam_pkg::data_t   o_xita;
  slam_pkg::data_t   o_lkx;
  slam_pkg::data_t   o_lky;
  logic              i_done_predict;
  logic              i_done_newlm;
  logic              i_done_update;
  slam_pkg::data_t   i_result_0;
  slam_pkg::data_t   i_result_1;
  slam_pkg::data_t   i_result_2;
  slam_pkg::data_t   i_result_3;
  slam_pkg::data_t   i_result_4;
  slam_pkg::data_t   i_result_5;

  // stimulus table, one stage per row
  string             row_name  [NUM_ROWS];
  slam_pkg::stage_t  row_stage [NUM_ROWS];
  int                row_lk    [NUM_ROWS];
  slam_pkg::data_t   row_rk    [NUM_ROWS];
  slam_pkg::data_t   row_phi   [NUM_ROWS];
  slam_pkg::data_t   row_res   [NUM_ROWS][6];

  // memory image the rules predict
  slam_pkg::data_t   ref_mem   [MEM_WORDS];
  int                init_cnt  = 0;
  int                cycle_cnt = 0;

  rsa_top DUT (.*);

  tb_wb_mem mem_model (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_cyc   (o_wb_cyc),
    .i_stb   (o_wb_stb),
    .i_we    (o_wb_we),
    .i_adr   (o_wb_adr),
    .i_dat   (o_wb_dat),
    .o_dat   (i_wb_dat),
    .o_ack   (i_wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(input string test, input string what,
                                 input slam_pkg::data_t exp, input slam_pkg::data_t act);
    $display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR: %s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string test, input string what,
                            input slam_pkg::data_t exp, input slam_pkg::data_t act);
    assert (exp == act) else report_mismatch(test, what, exp, act);
  endtask

  task automatic set_row(input int r, input string name, input slam_pkg::stage_t stage,
                         input int lk, input slam_pkg::data_t rk, input slam_pkg::data_t phi,
                         input slam_pkg::data_t r0, input slam_pkg::data_t r1,
                         input slam_pkg::data_t r2, input slam_pkg::data_t r3,
                         input slam_pkg::data_t r4, input slam_pkg::data_t r5);
    row_name[r]   = name;
    row_stage[r]  = stage;
    row_lk[r]     = lk;
    row_rk[r]     = rk;
    row_phi[r]    = phi;
    row_res[r][0] = r0;
    row_res[r][1] = r1;
    row_res[r][2] = r2;
    row_res[r][3] = r3;
    row_res[r][4] = r4;
    row_res[r][5] = r5;
  endtask

  // mixed kinds back to back, updates read slots written just before
  task automatic load_table();
    set_row(0, "predict_a", slam_pkg::STAGE_PRD, 0, 32'h0, 32'h0,
            32'h11, 32'h22, 32'h100, 32'h200, 32'h33, 32'h44);
    set_row(1, "update_lm3", slam_pkg::STAGE_UPD, 3, 32'h0000_4000, 32'h0000_0c00,
            32'h1234, 32'h0456, 32'h5, 32'h6, 32'h7, 32'h8);
    set_row(2, "newlm_lm5", slam_pkg::STAGE_NEW, 5, 32'h0, 32'h0,
            32'h1, 32'h2, 32'hffff_ff00, 32'h300, 32'h0, 32'h0);
    set_row(3, "update_lm5", slam_pkg::STAGE_UPD, 5, 32'h7fff_0000, -32'sd9,
            32'h0001_0000, -32'sd21, 32'h9, 32'ha, 32'hb, 32'hc);
    set_row(4, "predict_b", slam_pkg::STAGE_PRD, 0, 32'h0, 32'h0,
            32'h0, -32'sd40, -32'sd1000, 32'h8000_0000, 32'h0, 32'h0);
    set_row(5, "newlm_lm23", slam_pkg::STAGE_NEW, 23, 32'h0, 32'h0,
            32'h0, 32'h0, 32'h0abc_0000, -32'sd77, 32'h0, 32'h0);
    set_row(6, "update_lm23", slam_pkg::STAGE_UPD, 23, -32'sd5, 32'h1234_5678,
            32'h0000_0fff, 32'hfedc_ba98, 32'h1, 32'h2, 32'h3, 32'h4);
    set_row(7, "predict_c", slam_pkg::STAGE_PRD, 0, 32'h0, 32'h0,
            32'h5a5a_5a5a, 32'h1, 32'h2, 32'h3, 32'h4, 32'h5);
  endtask

  // expected writes of one stage
  task automatic apply_rules(input int r, input int lm_adr);
    case (row_stage[r])
      slam_pkg::STAGE_PRD: begin
        ref_mem[`SLAM_POSE_BASE]     = ref_mem[`SLAM_POSE_BASE] + row_res[r][2];
        ref_mem[`SLAM_POSE_BASE + 1] = ref_mem[`SLAM_POSE_BASE + 1] + row_res[r][3];
        ref_mem[`SLAM_POSE_BASE + 2] = ref_mem[`SLAM_POSE_BASE + 2] + row_res[r][1];
      end
      slam_pkg::STAGE_NEW: begin
        ref_mem[lm_adr]     = ref_mem[`SLAM_POSE_BASE] + row_res[r][3];
        ref_mem[lm_adr + 1] = ref_mem[`SLAM_POSE_BASE + 1] + row_res[r][2];
      end
      default: begin
        // innovation, measured minus predicted
        ref_mem[`SLAM_INNOV_BASE]     = row_rk[r] - row_res[r][0];
        ref_mem[`SLAM_INNOV_BASE + 1] = row_phi[r] - row_res[r][1];
      end
    endcase
  endtask

  task automatic compare_image(input string test);
    for (int a = 0; a < MEM_WORDS; a++) begin
      assert (mem_model.mem[a] == ref_mem[a])
        else report_mismatch(test, $sformatf("word %0d", a), ref_mem[a], mem_model.mem[a]);
    end
  endtask

  task automatic run_row(input int r);
    int              lm_adr;
    int              delay;
    slam_pkg::data_t exp_lkx;
    slam_pkg::data_t exp_lky;
    lm_adr = `SLAM_LM_BASE + 2 * row_lk[r];
    while (!o_stage_rdy) begin
      @(negedge clk);
    end
    i_stage_val = 1'b1;
    i_stage     = row_stage[r];
    i_l_k       = slam_pkg::lm_idx_t'(row_lk[r]);
    i_rk        = row_rk[r];
    i_phi       = row_phi[r];
    @(negedge clk);
    i_stage_val = 1'b0;
    assert (!o_stage_rdy)
      else report_problem($sformatf("%s: ready stayed high after acceptance", row_name[r]));
    // nonlinear unit side, wait for the init pulse
    while (!(o_init_predict || o_init_newlm || o_init_update)) begin
      @(negedge clk);
    end
    assert (o_init_predict == (row_stage[r] == slam_pkg::STAGE_PRD) &&
            o_init_newlm == (row_stage[r] == slam_pkg::STAGE_NEW) &&
            o_init_update == (row_stage[r] == slam_pkg::STAGE_UPD))
      else report_problem($sformatf("%s: wrong init line for this stage", row_name[r]));
    // landmark only in update, else the robot position
    if (row_stage[r] == slam_pkg::STAGE_UPD) begin
      exp_lkx = ref_mem[lm_adr];
      exp_lky = ref_mem[lm_adr + 1];
    end else begin
      exp_lkx = ref_mem[`SLAM_POSE_BASE];
      exp_lky = ref_mem[`SLAM_POSE_BASE + 1];
    end
    check_word(row_name[r], "xk", ref_mem[`SLAM_POSE_BASE], o_xk);
    check_word(row_name[r], "yk", ref_mem[`SLAM_POSE_BASE + 1], o_yk);
    check_word(row_name[r], "xita", ref_mem[`SLAM_POSE_BASE + 2], o_xita);
    check_word(row_name[r], "lkx", exp_lkx, o_lkx);
    check_word(row_name[r], "lky", exp_lky, o_lky);
    apply_rules(r, lm_adr);
    delay = $urandom_range(4, 1);
    repeat (delay) @(negedge clk);
    i_result_0 = row_res[r][0];
    i_result_1 = row_res[r][1];
    i_result_2 = row_res[r][2];
    i_result_3 = row_res[r][3];
    i_result_4 = row_res[r][4];
    i_result_5 = row_res[r][5];
    case (row_stage[r])
      slam_pkg::STAGE_PRD: i_done_predict = 1'b1;
      slam_pkg::STAGE_NEW: i_done_newlm   = 1'b1;
      default:             i_done_update  = 1'b1;
    endcase
    @(negedge clk);
    i_done_predict = 1'b0;
    i_done_newlm   = 1'b0;
    i_done_update  = 1'b0;
    // ready back up means the last write is done
    while (!o_stage_rdy) begin
      @(negedge clk);
    end
    assert (init_cnt == r + 1)
      else report_mismatch(row_name[r], "init pulses", slam_pkg::data_t'(r + 1),
                           slam_pkg::data_t'(init_cnt));
    compare_image(row_name[r]);
  endtask

  // init pulses and bus address range, sampled mid-cycle
  always @(negedge clk) begin
    if (!sys_rst) begin
      if (o_init_predict || o_init_newlm || o_init_update) begin
        init_cnt <= init_cnt + 1;
      end
      if (o_wb_cyc) begin
        assert (int'(o_wb_adr) < MEM_WORDS)
          else report_problem($sformatf("bus address %0d outside the memory", o_wb_adr));
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_problem($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    void'($urandom(SEED));
    load_table();
    sys_rst        = 1'b1;
    i_stage_val    = 1'b0;
    i_stage        = slam_pkg::STAGE_PRD;
    i_l_k          = '0;
    i_rk           = '0;
    i_phi          = '0;
    i_done_predict = 1'b0;
    i_done_newlm   = 1'b0;
    i_done_update  = 1'b0;
    i_result_0     = '0;
    i_result_1     = '0;
    i_result_2     = '0;
    i_result_3     = '0;
    i_result_4     = '0;
    i_result_5     = '0;
    repeat (2) @(negedge clk);
    sys_rst = 1'b0;
    @(negedge clk);
    assert (o_stage_rdy) else report_problem("ready is low after reset");
    assert (!(o_init_predict || o_init_newlm || o_init_update))
      else report_problem("an init line is high after reset");
    assert (!o_wb_cyc && !o_wb_stb) else report_problem("bus cycle open after reset");
    // reference starts from the random preset
    for (int a = 0; a < MEM_WORDS; a++) begin
      ref_mem[a] = mem_model.mem[a];
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== tb_wb_mem.sv ====
`timescale 1ns/10ps

module tb_wb_mem (
  input  logic            clk,
  input  logic            sys_rst,
  input  logic            i_cyc,
  input  logic            i_stb,
  input  logic            i_we,
  input  slam_pkg::addr_t i_adr,
  input  slam_pkg::data_t i_dat,
  output slam_pkg::data_t o_dat,
  output logic            o_ack
);

  localparam int MEM_WORDS = 64;

  slam_pkg::data_t mem [MEM_WORDS];
  logic            busy;
  logic [1:0]      wait_left;
  logic [5:0]      word;
  int              pick;

  // 64 words, upper address bits ignored
  assign word = i_adr[5:0];

  always @(posedge clk) begin
    if (sys_rst) begin
      // random preset, every word its own value
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= $urandom();
      end
      o_ack     <= 1'b0;
      o_dat     <= '0;
      busy      <= 1'b0;
      wait_left <= '0;
    end else begin
      o_ack <= 1'b0;
      if (i_cyc && i_stb && !o_ack) begin
        // 0 to 3 wait states, drawn once per cycle
        if (!busy) begin
          pick = $urandom_range(3, 0);
        end else begin
          pick = int'(wait_left);
        end
        if (pick == 0) begin
          o_ack <= 1'b1;
          busy  <= 1'b0;
          o_dat <= mem[word];
          if (i_we) begin
            mem[word] <= i_dat;
          end
        end else begin
          busy      <= 1'b1;
          wait_left <= 2'(pick - 1);
        end
      end
    end
  end

endmodule

// ==== rsa_top.sv ====
`timescale 1ns/10ps

module rsa_top (
  input  logic              clk,
  input  logic              sys_rst,
  // host stage request
  input  logic              i_stage_val,
  input  slam_pkg::stage_t  i_stage,
  input  slam_pkg::lm_idx_t i_l_k,
  input  slam_pkg::data_t   i_rk,
  input  slam_pkg::data_t   i_phi,
  output logic              o_stage_rdy,
  // shared bram, wishbone classic
  output logic              o_wb_cyc,
  output logic              o_wb_stb,
  output logic              o_wb_we,
  output slam_pkg::addr_t   o_wb_adr,
  output slam_pkg::data_t   o_wb_dat,
  input  slam_pkg::data_t   i_wb_dat,
  input  logic              i_wb_ack,
  // nonlinear unit
  output logic              o_init_predict,
  output logic              o_init_newlm,
  output logic              o_init_update,
  output slam_pkg::data_t   o_xk,
  output slam_pkg::data_t   o_yk,
  output slam_pkg::data_t   o_xita,
  output slam_pkg::data_t   o_lkx,
  output slam_pkg::data_t   o_lky,
  input  logic              i_done_predict,
  input  logic              i_done_newlm,
  input  logic              i_done_update,
  input  slam_pkg::data_t   i_result_0,
  input  slam_pkg::data_t   i_result_1,
  input  slam_pkg::data_t   i_result_2,
  input  slam_pkg::data_t   i_result_3,
  input  slam_pkg::data_t   i_result_4,
  input  slam_pkg::data_t   i_result_5
);

  // controller <-> bram port
  logic             req;
  logic             req_we;
  slam_pkg::addr_t  req_adr;
  logic             xfer_done;
  slam_pkg::data_t  rdata;
  // controller <-> datapath
  logic             load;
  logic [2:0]       word_idx;
  logic             capture;
  slam_pkg::stage_t stage_cur;
  slam_pkg::data_t  wdata;

  slam_stage_ctrl u_stage_ctrl (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (i_stage_val),
    .i_stage        (i_stage),
    .i_l_k          (i_l_k),
    .o_stage_rdy    (o_stage_rdy),
    .o_req          (req),
    .o_req_we       (req_we),
    .o_req_adr      (req_adr),
    .i_xfer_done    (xfer_done),
    .o_load         (load),
    .o_word_idx     (word_idx),
    .o_capture      (capture),
    .o_stage_cur    (stage_cur),
    .o_init_predict (o_init_predict),
    .o_init_newlm   (o_init_newlm),
    .o_init_update  (o_init_update),
    .i_done_predict (i_done_predict),
    .i_done_newlm   (i_done_newlm),
    .i_done_update  (i_done_update)
  );

  ekf_datapath u_datapath (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_load      (load),
    .i_word_idx  (word_idx),
    .i_rdata     (rdata),
    .i_capture   (capture),
    .i_stage_cur (stage_cur),
    .i_rk        (i_rk),
    .i_phi       (i_phi),
    .i_result_0  (i_result_0),
    .i_result_1  (i_result_1),
    .i_result_2  (i_result_2),
    .i_result_3  (i_result_3),
    .i_result_4  (i_result_4),
    .i_result_5  (i_result_5),
    .o_xk        (o_xk),
    .o_yk        (o_yk),
    .o_xita      (o_xita),
    .o_lkx       (o_lkx),
    .o_lky       (o_lky),
    .o_wdata     (wdata)
  );

  ps_bram_master u_bram_master (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_req       (req),
    .i_we        (req_we),
    .i_adr       (req_adr),
    .i_wdata     (wdata),
    .o_xfer_done (xfer_done),
    .o_rdata     (rdata),
    .o_wb_cyc    (o_wb_cyc),
    .o_wb_stb    (o_wb_stb),
    .o_wb_we     (o_wb_we),
    .o_wb_adr    (o_wb_adr),
    .o_wb_dat    (o_wb_dat),
    .i_wb_dat    (i_wb_dat),
    .i_wb_ack    (i_wb_ack)
  );

endmodule

// ==== slam_stage_ctrl.sv ====
`timescale 1ns/10ps

`include "slam_settings.svh"

module slam_stage_ctrl (
  input  logic              clk,
  input  logic              sys_rst,
  // host stage handshake
  input  logic              i_stage_val,
  input  slam_pkg::stage_t  i_stage,
  input  slam_pkg::lm_idx_t i_l_k,
  output logic              o_stage_rdy,
  // bram port requests
  output logic              o_req,
  output logic              o_req_we,
  output slam_pkg::addr_t   o_req_adr,
  input  logic              i_xfer_done,
  // datapath control
  output logic              o_load,
  output logic [2:0]        o_word_idx,
  output logic              o_capture,
  output slam_pkg::stage_t  o_stage_cur,
  // nonlinear unit
  output logic              o_init_predict,
  output logic              o_init_newlm,
  output logic              o_init_update,
  input  logic              i_done_predict,
  input  logic              i_done_newlm,
  input  logic              i_done_update
);

  slam_pkg::ctrl_state_t state_q;
  slam_pkg::stage_t      stage_q;
  slam_pkg::lm_idx_t     lk_q;
  slam_pkg::addr_t       lm_addr;
  logic [2:0]            cnt_q;
  logic                  req_q;
  logic                  accept;
  logic                  rd_last;
  logic                  wr_last;
  logic                  done_cur;

  // ready in idle and in the completion cycle
  assign o_stage_rdy = (state_q == slam_pkg::CTRL_IDLE) ||
                       (state_q == slam_pkg::CTRL_DONE);
  assign accept      = i_stage_val & o_stage_rdy;

  // word counts per stage
  // update also reads the landmark
  assign rd_last = (stage_q == slam_pkg::STAGE_UPD) ? (cnt_q == 3'd4) : (cnt_q == 3'd2);
  // pose writes three words, the others two
  assign wr_last = (stage_q == slam_pkg::STAGE_PRD) ? (cnt_q == 3'd2) : (cnt_q == 3'd1);

  // done line of the running stage
  always_comb begin
    case (stage_q)
      slam_pkg::STAGE_PRD: done_cur = i_done_predict;
      slam_pkg::STAGE_NEW: done_cur = i_done_newlm;
      slam_pkg::STAGE_UPD: done_cur = i_done_update;
      default:             done_cur = 1'b0;
    endcase
  end

  // stage fsm
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state_q <= slam_pkg::CTRL_IDLE;
      stage_q <= slam_pkg::STAGE_PRD;
      cnt_q   <= '0;
      req_q   <= 1'b0;
    end else begin
      // request is a single-cycle pulse
      req_q <= 1'b0;
      case (state_q)
        slam_pkg::CTRL_IDLE,
        slam_pkg::CTRL_DONE: begin
          state_q <= slam_pkg::CTRL_IDLE;
          if (accept) begin
            state_q <= slam_pkg::CTRL_READ;
            stage_q <= i_stage;
            cnt_q   <= '0;
            req_q   <= 1'b1;
          end
        end
        slam_pkg::CTRL_READ: begin
          if (i_xfer_done) begin
            if (rd_last) begin
              state_q <= slam_pkg::CTRL_INIT;
            end else begin
              cnt_q <= cnt_q + 3'd1;
              req_q <= 1'b1;
            end
          end
        end
        // init pulse lasts exactly this one cycle
        slam_pkg::CTRL_INIT: state_q <= slam_pkg::CTRL_WAIT;
        slam_pkg::CTRL_WAIT: begin
          if (done_cur) begin
            state_q <= slam_pkg::CTRL_WRITE;
            cnt_q   <= '0;
            req_q   <= 1'b1;
          end
        end
        slam_pkg::CTRL_WRITE: begin
          if (i_xfer_done) begin
            if (wr_last) begin
              state_q <= slam_pkg::CTRL_DONE;
            end else begin
              cnt_q <= cnt_q + 3'd1;
              req_q <= 1'b1;
            end
          end
        end
        default: state_q <= slam_pkg::CTRL_IDLE;
      endcase
    end
  end

  // landmark index held for the whole stage
  always_ff @(posedge clk) begin
    if (accept) begin
      lk_q <= i_l_k;
    end
  end

  // landmark slot base, two words per landmark
  assign lm_addr = slam_pkg::addr_t'(`SLAM_LM_BASE) + slam_pkg::addr_t'({lk_q, 1'b0});

  // address from the map, counter already points at the next word
  always_comb begin
    o_req_adr = slam_pkg::addr_t'(`SLAM_POSE_BASE) + slam_pkg::addr_t'(cnt_q);
    if (state_q == slam_pkg::CTRL_WRITE) begin
      case (stage_q)
        slam_pkg::STAGE_NEW: o_req_adr = lm_addr + slam_pkg::addr_t'(cnt_q);
        slam_pkg::STAGE_UPD:
          o_req_adr = slam_pkg::addr_t'(`SLAM_INNOV_BASE) + slam_pkg::addr_t'(cnt_q);
        default: ;
      endcase
    end else if (cnt_q >= 3'd3) begin
      // words 3 and 4 of an update read
      o_req_adr = lm_addr + slam_pkg::addr_t'(cnt_q - 3'd3);
    end
  end

  assign o_req    = req_q;
  assign o_req_we = (state_q == slam_pkg::CTRL_WRITE);

  // read words land in the datapath, acceptance samples rk and phi
  assign o_load     = accept | ((state_q == slam_pkg::CTRL_READ) & i_xfer_done);
  assign o_word_idx = accept ? `SLAM_IDX_STAGE : cnt_q;
  assign o_capture  = (state_q == slam_pkg::CTRL_WAIT) & done_cur;
  assign o_stage_cur = stage_q;

  assign o_init_predict = (state_q == slam_pkg::CTRL_INIT) && (stage_q == slam_pkg::STAGE_PRD);
  assign o_init_newlm   = (state_q == slam_pkg::CTRL_INIT) && (stage_q == slam_pkg::STAGE_NEW);
  assign o_init_update  = (state_q == slam_pkg::CTRL_INIT) && (stage_q == slam_pkg::STAGE_UPD);

  // nonlinear unit answers one stage at a time
  a_done_onehot : assert property (@(posedge clk) disable iff (sys_rst)
    $onehot0({i_done_predict, i_done_newlm, i_done_update}));

  // a done only while waiting, and only for the running stage
  a_done_match : assert property (@(posedge clk) disable iff (sys_rst)
    (i_done_predict | i_done_newlm | i_done_update) |->
      (state_q == slam_pkg::CTRL_WAIT) && done_cur);

  // host sends legal stage codes only
  a_stage_legal : assert property (@(posedge clk) disable iff (sys_rst)
    accept |-> (i_stage inside {slam_pkg::STAGE_PRD, slam_pkg::STAGE_NEW,
                                slam_pkg::STAGE_UPD}));

endmodule

// ==== ekf_datapath.sv ====
`timescale 1ns/10ps

`include "slam_settings.svh"

module ekf_datapath (
  input  logic             clk,
  input  logic             sys_rst,
  // operand loads from the bram port
  input  logic             i_load,
  input  logic [2:0]       i_word_idx,
  input  slam_pkg::data_t  i_rdata,
  // capture of nonlinear results
  input  logic             i_capture,
  input  slam_pkg::stage_t i_stage_cur,
  input  slam_pkg::data_t  i_rk,
  input  slam_pkg::data_t  i_phi,
  input  slam_pkg::data_t  i_result_0,
  input  slam_pkg::data_t  i_result_1,
  input  slam_pkg::data_t  i_result_2,
  input  slam_pkg::data_t  i_result_3,
  input  slam_pkg::data_t  i_result_4,
  input  slam_pkg::data_t  i_result_5,
  // operands to the nonlinear unit
  output slam_pkg::data_t  o_xk,
  output slam_pkg::data_t  o_yk,
  output slam_pkg::data_t  o_xita,
  output slam_pkg::data_t  o_lkx,
  output slam_pkg::data_t  o_lky,
  // write word for the current index
  output slam_pkg::data_t  o_wdata
);

  // robot state and landmark as read from bram
  slam_pkg::data_t xk_q;
  slam_pkg::data_t yk_q;
  slam_pkg::data_t xita_q;
  slam_pkg::data_t lmx_q;
  slam_pkg::data_t lmy_q;

  // measurement sampled at stage acceptance
  slam_pkg::data_t rk_q;
  slam_pkg::data_t phi_q;

  // up to three new estimates
  slam_pkg::data_t est0_q;
  slam_pkg::data_t est1_q;
  slam_pkg::data_t est2_q;

  // operand registers filled by the bram reads
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      xk_q   <= '0;
      yk_q   <= '0;
      xita_q <= '0;
      lmx_q  <= '0;
      lmy_q  <= '0;
    end else if (i_load) begin
      case (i_word_idx)
        3'd0: xk_q   <= i_rdata;
        3'd1: yk_q   <= i_rdata;
        3'd2: xita_q <= i_rdata;
        3'd3: lmx_q  <= i_rdata;
        3'd4: lmy_q  <= i_rdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_load && (i_word_idx == `SLAM_IDX_STAGE)) begin
      rk_q  <= i_rk;
      phi_q <= i_phi;
    end
  end

  // landmark operand in update and the robot position in the other stages
  assign o_lkx = (i_stage_cur == slam_pkg::STAGE_UPD) ? lmx_q : xk_q;
  assign o_lky = (i_stage_cur == slam_pkg::STAGE_UPD) ? lmy_q : yk_q;
  assign o_xk   = xk_q;
  assign o_yk   = yk_q;
  assign o_xita = xita_q;

  // estimate arithmetic in the done cycle
  always_ff @(posedge clk) begin
    if (i_capture) begin
      case (i_stage_cur)
        slam_pkg::STAGE_PRD: begin
          // pose + motion increment
          est0_q <= xk_q + i_result_2;
          est1_q <= yk_q + i_result_3;
          est2_q <= xita_q + i_result_1;
        end
        slam_pkg::STAGE_NEW: begin
          est0_q <= o_lkx + i_result_3;
          est1_q <= o_lky + i_result_2;
        end
        slam_pkg::STAGE_UPD: begin
          // innovation is measured minus predicted
          est0_q <= rk_q - i_result_0;
          est1_q <= phi_q - i_result_1;
        end
        default: ;
      endcase
    end
  end

  // write word by index
  always_comb begin
    case (i_word_idx)
      3'd0:    o_wdata = est0_q;
      3'd1:    o_wdata = est1_q;
      3'd2:    o_wdata = est2_q;
      default: o_wdata = '0;
    endcase
  end

  // all six results driven by the unit in its done cycle
  a_results_known : assert property (@(posedge clk) disable iff (sys_rst)
    i_capture |-> !$isunknown({i_result_0, i_result_1, i_result_2,
                               i_result_3, i_result_4, i_result_5}));

endmodule

// ==== ps_bram_master.sv ====
`timescale 1ns/10ps

module ps_bram_master (
  input  logic            clk,
  input  logic            sys_rst,
  // request side with one transfer per pulse
  input  logic            i_req,
  input  logic            i_we,
  input  slam_pkg::addr_t i_adr,
  input  slam_pkg::data_t i_wdata,
  output logic            o_xfer_done,
  output slam_pkg::data_t o_rdata,
  // wishbone classic master
  output logic            o_wb_cyc,
  output logic            o_wb_stb,
  output logic            o_wb_we,
  output slam_pkg::addr_t o_wb_adr,
  output slam_pkg::data_t o_wb_dat,
  input  slam_pkg::data_t i_wb_dat,
  input  logic            i_wb_ack
);

  logic            cyc_q;
  logic            stb_q;
  logic            we_q;
  slam_pkg::addr_t adr_q;
  slam_pkg::data_t dat_q;

  // idle <-> open cycle
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      cyc_q <= 1'b0;
      stb_q <= 1'b0;
    end else if (cyc_q) begin
      // close on ack so the bus idles at least one cycle
      if (i_wb_ack) begin
        cyc_q <= 1'b0;
        stb_q <= 1'b0;
      end
    end else if (i_req) begin
      cyc_q <= 1'b1;
      stb_q <= 1'b1;
    end
  end

  // address and data frozen for the whole cycle
  always_ff @(posedge clk) begin
    if (!cyc_q && i_req) begin
      we_q  <= i_we;
      adr_q <= i_adr;
      dat_q <= i_wdata;
    end
  end

  assign o_wb_cyc = cyc_q;
  assign o_wb_stb = stb_q;
  assign o_wb_we  = we_q;
  assign o_wb_adr = adr_q;
  assign o_wb_dat = dat_q;

  // read word only meaningful together with xfer_done
  assign o_xfer_done = cyc_q & stb_q & i_wb_ack;
  assign o_rdata     = i_wb_dat;

  // slave acks only while a strobe is open inside a cycle
  a_ack_in_stb : assert property (@(posedge clk) disable iff (sys_rst)
    i_wb_ack |-> o_wb_cyc && o_wb_stb);

  // controller must wait for xfer_done before the next request
  a_no_req_busy : assert property (@(posedge clk) disable iff (sys_rst)
    i_req |-> !o_wb_cyc);

endmodule

// ==== slam_pkg.sv ====
package slam_pkg;

`include "slam_settings.svh"

  // one BRAM word, signed fixed point
  typedef logic signed [`SLAM_DW-1:0] data_t;

  // word address into the shared BRAM
  typedef logic [`SLAM_AW-1:0] addr_t;

  // landmark slot number
  typedef logic [`SLAM_LW-1:0] lm_idx_t;

  // stage codes from the host
  // code 2'd3 is illegal
  typedef enum logic [1:0] {
    STAGE_PRD = 2'd0,
    STAGE_NEW = 2'd1,
    STAGE_UPD = 2'd2
  } stage_t;

  // stage controller states
  typedef enum logic [2:0] {
    CTRL_IDLE  = 3'd0,
    CTRL_READ  = 3'd1,
    CTRL_INIT  = 3'd2,
    CTRL_WAIT  = 3'd3,
    CTRL_WRITE = 3'd4,
    CTRL_DONE  = 3'd5
  } ctrl_state_t;

endpackage

// ==== slam_settings.svh ====
`ifndef SLAM_SETTINGS_SVH
`define SLAM_SETTINGS_SVH

// word width of the shared BRAM and of every estimate
`define SLAM_DW 32

// word address width on the Wishbone side
`define SLAM_AW 10

// landmark index width
`define SLAM_LW 8

// robot pose x, y, theta in three consecutive words
`define SLAM_POSE_BASE 0

// innovation pair rk - r0, phi - r1
`define SLAM_INNOV_BASE 4

// landmark k sits at base + 2k (x) and the word after it (y)
`define SLAM_LM_BASE 16

// load index used at stage acceptance to sample rk and phi
`define SLAM_IDX_STAGE 3'd7

`endif
